//--- all.f
+incdir+source
source/rv_exec_pkg.sv
source/rv_alu.sv
source/exec_issue.sv
source/div_stage.sv
source/exec_retire.sv
source/rv_exec_top.sv
testbench/rv_exec_assertions.sv
testbench/tb_rv_exec.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; status follows the pass message in the output
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_rv_exec \
  -Mdir obj_dir -o sim_rv_exec \
  && ./obj_dir/sim_rv_exec | grep -F "** PASS **" \
  || { echo "Simulation did not pass"; exit 1; }

//--- source/div_stage.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module div_stage (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_advance,
  input  rv_exec_pkg::div_lane_t i_lane,
  output rv_exec_pkg::div_lane_t o_lane
);

  rv_exec_pkg::div_lane_t lane_d;
  rv_exec_pkg::div_lane_t lane_q;
  logic                   lane_valid;

  // Restoring steps, MSB of the dividend first
  always_comb begin : steps
    rv_exec_pkg::rem_t shifted;
    lane_d = i_lane;
    for (int s = 0; s < `DIV_BITS_PER_STAGE; s++) begin
      shifted     = {lane_d.rem[`XLEN-1:0], lane_d.quot[`XLEN-1]};
      lane_d.quot = {lane_d.quot[`XLEN-2:0], 1'b0};
      if (shifted >= {1'b0, lane_d.divisor}) begin
        lane_d.rem     = shifted - {1'b0, lane_d.divisor};
        lane_d.quot[0] = 1'b1;
      end else begin
        lane_d.rem = shifted;  // Restore
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      lane_valid <= 1'b0;
    end else if (i_advance) begin
      lane_valid <= i_lane.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_advance && i_lane.valid) begin
      lane_q <= lane_d;
    end
  end

  always_comb begin
    o_lane       = lane_q;
    o_lane.valid = lane_valid;
  end

endmodule

//--- source/exec_issue.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module exec_issue (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_req_valid,
  output logic                   o_req_ready,
  input  rv_exec_pkg::exec_req_t i_req,
  input  logic                   i_advance,
  input  logic                   i_div_pop,
  output logic                   o_alu_valid,
  output rv_exec_pkg::exec_req_t o_alu_req,
  output rv_exec_pkg::div_lane_t o_lane
);

  rv_exec_pkg::div_cnt_t  inflight;
  rv_exec_pkg::div_lane_t lane_d;
  rv_exec_pkg::div_lane_t lane_q;
  logic                   lane_valid;
  logic                   is_div;
  logic                   is_signed;
  logic                   sign_a;
  logic                   sign_b;
  logic                   div_go;

  assign is_div    = i_req.op inside {rv_exec_pkg::OP_DIV, rv_exec_pkg::OP_DIVU,
                                      rv_exec_pkg::OP_REM, rv_exec_pkg::OP_REMU};
  assign is_signed = i_req.op inside {rv_exec_pkg::OP_DIV, rv_exec_pkg::OP_REM};
  assign sign_a    = is_signed && i_req.rs1[`XLEN-1];
  assign sign_b    = is_signed && i_req.rs2[`XLEN-1];

  // ALU ops wait until every older divide has left the chain
  assign o_req_ready = i_advance && (is_div || inflight == '0);
  assign div_go      = i_req_valid && o_req_ready && is_div;
  assign o_alu_valid = i_req_valid && o_req_ready && !is_div;
  assign o_alu_req   = i_req;

  always_comb begin
    lane_d          = '0;
    lane_d.valid    = 1'b1;
    lane_d.quot     = sign_a ? -i_req.rs1 : i_req.rs1;  // Dividend magnitude
    lane_d.divisor  = sign_b ? -i_req.rs2 : i_req.rs2;
    lane_d.neg_quot = (sign_a ^ sign_b) && (i_req.rs2 != '0);  // Div by zero stays all ones
    lane_d.neg_rem  = sign_a;
    lane_d.want_rem = i_req.op inside {rv_exec_pkg::OP_REM, rv_exec_pkg::OP_REMU};
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      inflight   <= '0;
      lane_valid <= 1'b0;
    end else begin
      if (div_go && !i_div_pop) begin
        inflight <= inflight + rv_exec_pkg::div_cnt_t'(1);
      end else if (!div_go && i_div_pop) begin
        inflight <= inflight - rv_exec_pkg::div_cnt_t'(1);
      end
      if (i_advance) begin
        lane_valid <= div_go;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (div_go) begin
      lane_q <= lane_d;
    end
  end

  always_comb begin
    o_lane       = lane_q;
    o_lane.valid = lane_valid;
  end

endmodule

//--- source/exec_retire.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module exec_retire (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_alu_valid,
  input  rv_exec_pkg::exec_rsp_t i_alu_rsp,
  input  rv_exec_pkg::div_lane_t i_lane,
  output logic                   o_advance,
  output logic                   o_div_pop,
  output logic                   o_rsp_valid,
  input  logic                   i_rsp_ready,
  output rv_exec_pkg::exec_rsp_t o_rsp
);

  rv_exec_pkg::xword_t    quot_fix;
  rv_exec_pkg::xword_t    rem_fix;
  rv_exec_pkg::exec_rsp_t div_rsp;
  logic                   load;

  // Response register free or draining this cycle
  assign o_advance = !o_rsp_valid || i_rsp_ready;
  assign o_div_pop = o_advance && i_lane.valid;
  assign load      = o_advance && (i_alu_valid || i_lane.valid);

  assign quot_fix = i_lane.neg_quot ? -i_lane.quot : i_lane.quot;
  assign rem_fix  = i_lane.neg_rem ? -i_lane.rem[`XLEN-1:0] : i_lane.rem[`XLEN-1:0];

  always_comb begin
    div_rsp         = '0;
    div_rsp.rd_data = i_lane.want_rem ? rem_fix : quot_fix;
    div_rsp.rd_we   = 1'b1;
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rsp_valid <= 1'b0;
    end else if (o_advance) begin
      o_rsp_valid <= i_alu_valid || i_lane.valid;
    end
  end

  // Issue rule keeps ALU and divide from arriving together
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_rsp <= i_lane.valid ? div_rsp : i_alu_rsp;
    end
  end

endmodule

//--- source/rv_alu.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module rv_alu (
  input  rv_exec_pkg::exec_req_t i_req,
  output rv_exec_pkg::exec_rsp_t o_rsp
);

  rv_exec_pkg::xword_t a;
  rv_exec_pkg::xword_t b;
  rv_exec_pkg::xword_t imm_i;
  rv_exec_pkg::xword_t imm_b;
  rv_exec_pkg::xword_t imm_j;
  rv_exec_pkg::xword_t imm_u;
  rv_exec_pkg::xword_t uimm;
  rv_exec_pkg::xword_t csr_src;
  rv_exec_pkg::xword_t jalr_sum;
  rv_exec_pkg::dword_t prod_ss;
  rv_exec_pkg::dword_t prod_su;
  rv_exec_pkg::dword_t prod_uu;
  logic [4:0]          shamt_i;
  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                is_branch;

  assign a = i_req.rs1;
  assign b = i_req.rs2;

  assign imm_i   = {{(`XLEN-12){i_req.ir[31]}}, i_req.ir[31:20]};
  assign imm_b   = {{(`XLEN-13){i_req.ir[31]}}, i_req.ir[31], i_req.ir[7],
                    i_req.ir[30:25], i_req.ir[11:8], 1'b0};
  assign imm_j   = {{(`XLEN-21){i_req.ir[31]}}, i_req.ir[31], i_req.ir[19:12],
                    i_req.ir[20], i_req.ir[30:21], 1'b0};
  assign imm_u   = {i_req.ir[31:12], 12'b0};
  assign uimm    = {{(`XLEN-5){1'b0}}, i_req.ir[19:15]};  // CSR immediate sits in rs1 field
  assign shamt_i = i_req.ir[24:20];

  assign eq   = (a == b);
  assign lt_s = ($signed(a) < $signed(b));
  assign lt_u = (a < b);

  // All three products at full width; only the needed half is used
  assign prod_ss = $signed(a) * $signed(b);
  assign prod_su = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{1'b0}}, b};
  assign prod_uu = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};

  assign jalr_sum = a + imm_i;
  assign csr_src  = (i_req.op inside {rv_exec_pkg::OP_CSRRWI, rv_exec_pkg::OP_CSRRSI,
                                      rv_exec_pkg::OP_CSRRCI}) ? uimm : a;

  assign is_branch = i_req.op inside {rv_exec_pkg::OP_BEQ, rv_exec_pkg::OP_BNE,
                                      rv_exec_pkg::OP_BLT, rv_exec_pkg::OP_BGE,
                                      rv_exec_pkg::OP_BLTU, rv_exec_pkg::OP_BGEU};

  always_comb begin
    o_rsp = '0;
    case (i_req.op)
      rv_exec_pkg::OP_ADD:    o_rsp.rd_data = a + b;
      rv_exec_pkg::OP_SUB:    o_rsp.rd_data = a - b;
      rv_exec_pkg::OP_SLL:    o_rsp.rd_data = a << b[4:0];
      rv_exec_pkg::OP_SLT:    o_rsp.rd_data = {{(`XLEN-1){1'b0}}, lt_s};
      rv_exec_pkg::OP_SLTU:   o_rsp.rd_data = {{(`XLEN-1){1'b0}}, lt_u};
      rv_exec_pkg::OP_XOR:    o_rsp.rd_data = a ^ b;
      rv_exec_pkg::OP_SRL:    o_rsp.rd_data = a >> b[4:0];
      rv_exec_pkg::OP_SRA:    o_rsp.rd_data = $signed(a) >>> b[4:0];
      rv_exec_pkg::OP_OR:     o_rsp.rd_data = a | b;
      rv_exec_pkg::OP_AND:    o_rsp.rd_data = a & b;
      rv_exec_pkg::OP_ADDI:   o_rsp.rd_data = a + imm_i;
      rv_exec_pkg::OP_SLTI:   o_rsp.rd_data = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(imm_i)};
      rv_exec_pkg::OP_SLTIU:  o_rsp.rd_data = {{(`XLEN-1){1'b0}}, a < imm_i};
      rv_exec_pkg::OP_XORI:   o_rsp.rd_data = a ^ imm_i;
      rv_exec_pkg::OP_ORI:    o_rsp.rd_data = a | imm_i;
      rv_exec_pkg::OP_ANDI:   o_rsp.rd_data = a & imm_i;
      rv_exec_pkg::OP_SLLI:   o_rsp.rd_data = a << shamt_i;
      rv_exec_pkg::OP_SRLI:   o_rsp.rd_data = a >> shamt_i;
      rv_exec_pkg::OP_SRAI:   o_rsp.rd_data = $signed(a) >>> shamt_i;
      rv_exec_pkg::OP_MUL:    o_rsp.rd_data = prod_ss[`XLEN-1:0];
      rv_exec_pkg::OP_MULH:   o_rsp.rd_data = prod_ss[2*`XLEN-1:`XLEN];
      rv_exec_pkg::OP_MULHSU: o_rsp.rd_data = prod_su[2*`XLEN-1:`XLEN];
      rv_exec_pkg::OP_MULHU:  o_rsp.rd_data = prod_uu[2*`XLEN-1:`XLEN];
      rv_exec_pkg::OP_BEQ:    o_rsp.jump = eq;
      rv_exec_pkg::OP_BNE:    o_rsp.jump = !eq;
      rv_exec_pkg::OP_BLT:    o_rsp.jump = lt_s;
      rv_exec_pkg::OP_BGE:    o_rsp.jump = !lt_s;
      rv_exec_pkg::OP_BLTU:   o_rsp.jump = lt_u;
      rv_exec_pkg::OP_BGEU:   o_rsp.jump = !lt_u;
      rv_exec_pkg::OP_JAL: begin
        o_rsp.jump      = 1'b1;
        o_rsp.jump_addr = i_req.pc + imm_j;
        o_rsp.rd_data   = i_req.pc + `XLEN'd4;  // Link address
      end
      rv_exec_pkg::OP_JALR: begin
        o_rsp.jump      = 1'b1;
        o_rsp.jump_addr = {jalr_sum[`XLEN-1:1], 1'b0};
        o_rsp.rd_data   = i_req.pc + `XLEN'd4;
      end
      rv_exec_pkg::OP_LUI:    o_rsp.rd_data = imm_u;
      rv_exec_pkg::OP_AUIPC:  o_rsp.rd_data = i_req.pc + imm_u;
      rv_exec_pkg::OP_CSRRW,
      rv_exec_pkg::OP_CSRRWI: o_rsp.csr_wdata = csr_src;
      rv_exec_pkg::OP_CSRRS,
      rv_exec_pkg::OP_CSRRSI: o_rsp.csr_wdata = i_req.csr_rdata | csr_src;
      rv_exec_pkg::OP_CSRRC,
      rv_exec_pkg::OP_CSRRCI: o_rsp.csr_wdata = i_req.csr_rdata & ~csr_src;
      default: ;  // Divides and SYS leave everything zero
    endcase

    if (is_branch) begin
      o_rsp.jump_addr = i_req.pc + imm_b;  // Target reported even when not taken
    end

    o_rsp.csr_we = i_req.op inside {rv_exec_pkg::OP_CSRRW, rv_exec_pkg::OP_CSRRS,
                                    rv_exec_pkg::OP_CSRRC, rv_exec_pkg::OP_CSRRWI,
                                    rv_exec_pkg::OP_CSRRSI, rv_exec_pkg::OP_CSRRCI};
    if (o_rsp.csr_we) begin
      o_rsp.rd_data = i_req.csr_rdata;  // Old CSR value goes to rd
    end

    // Everything but branches, divides and SYS writes rd
    o_rsp.rd_we = !(is_branch ||
                    i_req.op inside {rv_exec_pkg::OP_DIV, rv_exec_pkg::OP_DIVU,
                                     rv_exec_pkg::OP_REM, rv_exec_pkg::OP_REMU,
                                     rv_exec_pkg::OP_SYS});
  end

endmodule

//--- source/rv_exec_cfg.svh
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// Datapath width of the core
`define XLEN 32

// Quotient bits resolved per divider stage, must divide XLEN evenly
`define DIV_BITS_PER_STAGE 4

// Number of divider stages in the chain
`define DIV_STAGES (`XLEN / `DIV_BITS_PER_STAGE)

`endif

//--- source/rv_exec_pkg.sv
`include "rv_exec_cfg.svh"

package rv_exec_pkg;

  typedef logic [`XLEN-1:0]   xword_t;  // Data words and addresses
  typedef logic [2*`XLEN-1:0] dword_t;  // Full multiplier product
  typedef logic [`XLEN:0]     rem_t;    // Partial remainder, one guard bit
  typedef logic [31:0]        instr_t;  // Raw instruction word

  // Divides in flight, issue register plus every stage
  typedef logic [$clog2(`DIV_STAGES+2)-1:0] div_cnt_t;

  typedef enum logic [5:0] {
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
    OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_JAL, OP_JALR, OP_LUI, OP_AUIPC,
    OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
    OP_SYS  // FENCE, ECALL, MRET and friends
  } exec_op_e;

  typedef struct packed {
    exec_op_e op;
    instr_t   ir;         // Immediates come from here
    xword_t   rs1;
    xword_t   rs2;
    xword_t   pc;
    xword_t   csr_rdata;  // Current CSR value read by the caller
  } exec_req_t;

  typedef struct packed {
    xword_t rd_data;
    logic   rd_we;
    logic   jump;
    xword_t jump_addr;
    logic   csr_we;
    xword_t csr_wdata;
  } exec_rsp_t;

  typedef struct packed {
    logic   valid;
    rem_t   rem;       // Partial remainder
    xword_t quot;      // Dividend bits shift out, quotient bits shift in
    xword_t divisor;   // Magnitude
    logic   neg_quot;
    logic   neg_rem;
    logic   want_rem;  // REM/REMU instead of DIV/DIVU
  } div_lane_t;

endpackage

//--- source/rv_exec_top.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module rv_exec_top (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_req_valid,
  output logic                   o_req_ready,
  input  rv_exec_pkg::exec_req_t i_req,
  output logic                   o_rsp_valid,
  input  logic                   i_rsp_ready,
  output rv_exec_pkg::exec_rsp_t o_rsp
);

  logic                   advance;   // Global pipeline enable
  logic                   div_pop;
  logic                   alu_valid;
  rv_exec_pkg::exec_req_t alu_req;
  rv_exec_pkg::exec_rsp_t alu_rsp;
  rv_exec_pkg::div_lane_t lane [`DIV_STAGES+1];  // lane[0] from issue, last to retire

  exec_issue i_exec_issue (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req       (i_req),
    .i_advance   (advance),
    .i_div_pop   (div_pop),
    .o_alu_valid (alu_valid),
    .o_alu_req   (alu_req),
    .o_lane      (lane[0])
  );

  rv_alu i_rv_alu (
    .i_req (alu_req),
    .o_rsp (alu_rsp)
  );

  for (genvar k = 0; k < `DIV_STAGES; k++) begin : g_div
    div_stage i_div_stage (
      .i_clk     (i_clk),
      .i_arst_n  (i_arst_n),
      .i_advance (advance),
      .i_lane    (lane[k]),
      .o_lane    (lane[k+1])
    );
  end

  exec_retire i_exec_retire (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_alu_valid (alu_valid),
    .i_alu_rsp   (alu_rsp),
    .i_lane      (lane[`DIV_STAGES]),
    .o_advance   (advance),
    .o_div_pop   (div_pop),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp       (o_rsp)
  );

endmodule

//--- testbench/rv_exec_assertions.sv
`timescale 1ns/1ps

module rv_exec_assertions (
  input logic                   i_clk,
  input logic                   i_arst_n,
  input logic                   i_req_valid,
  input logic                   i_req_ready,
  input logic                   i_rsp_valid,
  input logic                   i_rsp_ready,
  input rv_exec_pkg::exec_rsp_t i_rsp
);

  logic seen_req;  // Some request accepted since reset

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      seen_req <= 1'b0;
    end else if (i_req_valid && i_req_ready) begin
      seen_req <= 1'b1;
    end
  end

  a_reset_idle: assert property (@(posedge i_clk) !i_arst_n |-> !i_rsp_valid)
    else $error("Response valid while in reset");

  a_rsp_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_rsp_valid && !i_rsp_ready |=> $stable(i_rsp))
    else $error("Response changed while stalled");

  a_rsp_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_rsp_valid && !i_rsp_ready |=> i_rsp_valid)
    else $error("Response valid dropped before it was taken");

  a_rsp_after_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_rsp_valid |-> seen_req)
    else $error("Response without any accepted request");

endmodule

bind rv_exec_top rv_exec_assertions i_rv_exec_assertions (
  .i_clk       (i_clk),
  .i_arst_n    (i_arst_n),
  .i_req_valid (i_req_valid),
  .i_req_ready (o_req_ready),
  .i_rsp_valid (o_rsp_valid),
  .i_rsp_ready (i_rsp_ready),
  .i_rsp       (o_rsp)
);

//--- testbench/tb_rv_exec.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module tb_rv_exec;

  // About 300 transactions at no more than DIV_STAGES+2 cycles, plus margin
  localparam int MAX_CYCLES = 300 * (`DIV_STAGES + 2) + 1000;

  logic                   i_clk;
  logic                   i_arst_n;
  logic                   i_req_valid;
  logic                   o_req_ready;
  rv_exec_pkg::exec_req_t i_req;
  logic                   o_rsp_valid;
  logic                   i_rsp_ready = 1'b1;
  rv_exec_pkg::exec_rsp_t o_rsp;

  rv_exec_pkg::exec_rsp_t exp_q[$];   // Expected responses in request order
  string                  name_q[$];
  logic                   bp_en = 1'b0;  // Random back-pressure on the response port
  int                     cycles;

  rv_exec_top i_rv_exec_top (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req       (i_req),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp       (o_rsp)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic check(string tname, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s: expected %h, actual %h", tname, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic compare_rsp(string tname, rv_exec_pkg::exec_rsp_t e,
                             rv_exec_pkg::exec_rsp_t a);
    check({tname, " rd_data"}, e.rd_data, a.rd_data);
    check({tname, " rd_we"}, 32'(e.rd_we), 32'(a.rd_we));
    check({tname, " jump"}, 32'(e.jump), 32'(a.jump));
    check({tname, " jump_addr"}, e.jump_addr, a.jump_addr);
    check({tname, " csr_we"}, 32'(e.csr_we), 32'(a.csr_we));
    check({tname, " csr_wdata"}, e.csr_wdata, a.csr_wdata);
  endtask

  // RISC-V divide rules, including divide by zero and signed overflow
  function automatic logic [31:0] div_ref(rv_exec_pkg::exec_op_e op, logic [31:0] a,
                                          logic [31:0] b);
    case (op)
      rv_exec_pkg::OP_DIVU: return (b == 32'h0) ? 32'hffff_ffff : a / b;
      rv_exec_pkg::OP_REMU: return (b == 32'h0) ? a : a % b;
      rv_exec_pkg::OP_DIV: begin
        if (b == 32'h0) return 32'hffff_ffff;
        else if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
        else return $signed(a) / $signed(b);
      end
      default: begin
        if (b == 32'h0) return a;
        else if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h0;
        else return $signed(a) % $signed(b);
      end
    endcase
  endfunction

  function automatic rv_exec_pkg::exec_rsp_t model(rv_exec_pkg::exec_req_t r);
    rv_exec_pkg::exec_rsp_t e;
    logic [31:0]            a;
    logic [31:0]            b;
    logic [31:0]            ii;
    logic [31:0]            ib;
    logic [31:0]            ij;
    logic [31:0]            src;
    logic signed [63:0]     sa;
    logic signed [63:0]     sb;
    logic [63:0]            ub;
    logic                   is_br;
    e   = '0;
    a   = r.rs1;
    b   = r.rs2;
    ii  = {{20{r.ir[31]}}, r.ir[31:20]};
    ib  = {{20{r.ir[31]}}, r.ir[7], r.ir[30:25], r.ir[11:8], 1'b0};
    ij  = {{12{r.ir[31]}}, r.ir[19:12], r.ir[20], r.ir[30:21], 1'b0};
    src = (r.op inside {rv_exec_pkg::OP_CSRRWI, rv_exec_pkg::OP_CSRRSI,
                        rv_exec_pkg::OP_CSRRCI}) ? {27'h0, r.ir[19:15]} : a;
    sa  = {{32{a[31]}}, a};
    sb  = {{32{b[31]}}, b};
    ub  = {32'h0, b};
    case (r.op)
      rv_exec_pkg::OP_ADD:    e.rd_data = a + b;
      rv_exec_pkg::OP_SUB:    e.rd_data = a - b;
      rv_exec_pkg::OP_SLL:    e.rd_data = a << b[4:0];
      rv_exec_pkg::OP_SLT:    e.rd_data = {31'h0, $signed(a) < $signed(b)};
      rv_exec_pkg::OP_SLTU:   e.rd_data = {31'h0, a < b};
      rv_exec_pkg::OP_XOR:    e.rd_data = a ^ b;
      rv_exec_pkg::OP_SRL:    e.rd_data = a >> b[4:0];
      rv_exec_pkg::OP_SRA:    e.rd_data = $signed(a) >>> b[4:0];
      rv_exec_pkg::OP_OR:     e.rd_data = a | b;
      rv_exec_pkg::OP_AND:    e.rd_data = a & b;
      rv_exec_pkg::OP_ADDI:   e.rd_data = a + ii;
      rv_exec_pkg::OP_SLTI:   e.rd_data = {31'h0, $signed(a) < $signed(ii)};
      rv_exec_pkg::OP_SLTIU:  e.rd_data = {31'h0, a < ii};
      rv_exec_pkg::OP_XORI:   e.rd_data = a ^ ii;
      rv_exec_pkg::OP_ORI:    e.rd_data = a | ii;
      rv_exec_pkg::OP_ANDI:   e.rd_data = a & ii;
      rv_exec_pkg::OP_SLLI:   e.rd_data = a << r.ir[24:20];
      rv_exec_pkg::OP_SRLI:   e.rd_data = a >> r.ir[24:20];
      rv_exec_pkg::OP_SRAI:   e.rd_data = $signed(a) >>> r.ir[24:20];
      rv_exec_pkg::OP_MUL:    e.rd_data = 32'(sa * sb);
      rv_exec_pkg::OP_MULH:   e.rd_data = 32'((sa * sb) >> 32);
      rv_exec_pkg::OP_MULHSU: e.rd_data = 32'((sa * $signed(ub)) >> 32);
      rv_exec_pkg::OP_MULHU:  e.rd_data = 32'(({32'h0, a} * ub) >> 32);
      rv_exec_pkg::OP_DIV, rv_exec_pkg::OP_DIVU,
      rv_exec_pkg::OP_REM, rv_exec_pkg::OP_REMU: e.rd_data = div_ref(r.op, a, b);
      rv_exec_pkg::OP_BEQ:    e.jump = (a == b);
      rv_exec_pkg::OP_BNE:    e.jump = (a != b);
      rv_exec_pkg::OP_BLT:    e.jump = ($signed(a) < $signed(b));
      rv_exec_pkg::OP_BGE:    e.jump = ($signed(a) >= $signed(b));
      rv_exec_pkg::OP_BLTU:   e.jump = (a < b);
      rv_exec_pkg::OP_BGEU:   e.jump = (a >= b);
      rv_exec_pkg::OP_JAL: begin
        e.jump      = 1'b1;
        e.jump_addr = r.pc + ij;
        e.rd_data   = r.pc + 32'd4;
      end
      rv_exec_pkg::OP_JALR: begin
        e.jump      = 1'b1;
        e.jump_addr = (a + ii) & 32'hffff_fffe;
        e.rd_data   = r.pc + 32'd4;
      end
      rv_exec_pkg::OP_LUI:    e.rd_data = {r.ir[31:12], 12'h0};
      rv_exec_pkg::OP_AUIPC:  e.rd_data = r.pc + {r.ir[31:12], 12'h0};
      rv_exec_pkg::OP_CSRRW, rv_exec_pkg::OP_CSRRWI: e.csr_wdata = src;
      rv_exec_pkg::OP_CSRRS, rv_exec_pkg::OP_CSRRSI: e.csr_wdata = r.csr_rdata | src;
      rv_exec_pkg::OP_CSRRC, rv_exec_pkg::OP_CSRRCI: e.csr_wdata = r.csr_rdata & ~src;
      default: ;
    endcase
    is_br = r.op inside {[rv_exec_pkg::OP_BEQ:rv_exec_pkg::OP_BGEU]};
    if (is_br) e.jump_addr = r.pc + ib;  // Branch target, taken or not
    if (r.op inside {[rv_exec_pkg::OP_CSRRW:rv_exec_pkg::OP_CSRRCI]}) begin
      e.csr_we  = 1'b1;
      e.rd_data = r.csr_rdata;
    end
    e.rd_we = !(is_br || r.op == rv_exec_pkg::OP_SYS);
    return e;
  endfunction

  // Edge operands mixed with random ones
  function automatic logic [31:0] pick();
    case ($urandom % 8)
      0: return 32'h0;
      1: return 32'h1;
      2: return 32'hffff_ffff;
      3: return 32'h8000_0000;
      4: return 32'h7fff_ffff;
      default: return $urandom;
    endcase
  endfunction

  // Called on a rising edge, returns on the edge that accepted the request
  task automatic send(string tname, rv_exec_pkg::exec_op_e op, logic [31:0] a,
                      logic [31:0] b);
    rv_exec_pkg::exec_req_t r;
    logic                   rdy;
    r.op        = op;
    r.ir        = $urandom;
    r.rs1       = a;
    r.rs2       = b;
    r.pc        = $urandom & 32'hffff_fffc;
    r.csr_rdata = $urandom;
    exp_q.push_back(model(r));
    name_q.push_back(tname);
    i_req_valid <= 1'b1;
    i_req       <= r;
    do begin
      @(negedge i_clk);
      rdy = o_req_ready;
      @(posedge i_clk);
    end while (!rdy);
  endtask

  task automatic drain();
    i_req_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge i_clk);
  endtask

  task automatic test_int();
    for (int o = rv_exec_pkg::OP_ADD; o <= rv_exec_pkg::OP_SRAI; o++) begin
      for (int k = 0; k < 4; k++) send("int", rv_exec_pkg::exec_op_e'(o), pick(), pick());
    end
    drain();
  endtask

  task automatic test_mul();
    for (int o = rv_exec_pkg::OP_MUL; o <= rv_exec_pkg::OP_MULHU; o++) begin
      send("mul", rv_exec_pkg::exec_op_e'(o), 32'h8000_0000, 32'h8000_0000);
      send("mul", rv_exec_pkg::exec_op_e'(o), 32'hffff_fff9, 32'h0000_0123);
      for (int k = 0; k < 5; k++) send("mul", rv_exec_pkg::exec_op_e'(o), pick(), pick());
    end
    drain();
  endtask

  task automatic test_ctrl();
    logic [31:0] a;
    for (int o = rv_exec_pkg::OP_BEQ; o <= rv_exec_pkg::OP_AUIPC; o++) begin
      for (int k = 0; k < 4; k++) begin
        a = pick();
        send("ctrl", rv_exec_pkg::exec_op_e'(o), a, ($urandom % 2 == 0) ? a : pick());
      end
    end
    drain();
  endtask

  task automatic test_csr();
    for (int o = rv_exec_pkg::OP_CSRRW; o <= rv_exec_pkg::OP_SYS; o++) begin
      for (int k = 0; k < 3; k++) send("csr", rv_exec_pkg::exec_op_e'(o), pick(), pick());
    end
    drain();
  endtask

  // Back-to-back divides keep the divider pipeline full
  task automatic test_div();
    int t_start;
    t_start = cycles;
    for (int o = rv_exec_pkg::OP_DIV; o <= rv_exec_pkg::OP_REMU; o++) begin
      send("div", rv_exec_pkg::exec_op_e'(o), $urandom, 32'h0);
      send("div", rv_exec_pkg::exec_op_e'(o), 32'h8000_0000, 32'hffff_ffff);
      for (int k = 0; k < 8; k++) send("div", rv_exec_pkg::exec_op_e'(o), pick(), pick());
    end
    // 40 divides with no back-pressure, one accepted per cycle
    check("div back-to-back issue cycles", 32'd40, 32'(cycles - t_start));
    drain();
  endtask

  task automatic test_mixed();
    bp_en = 1'b1;
    for (int k = 0; k < 120; k++) begin
      send("mixed", rv_exec_pkg::exec_op_e'($urandom % (rv_exec_pkg::OP_SYS + 1)),
           pick(), pick());
    end
    drain();
    bp_en = 1'b0;
  endtask

  always @(posedge i_clk) begin
    if (bp_en) i_rsp_ready <= ($urandom % 4) != 0;
    else i_rsp_ready <= 1'b1;
  end

  // Response monitor, pairs each taken response with the oldest request
  always @(posedge i_clk) begin
    if (o_rsp_valid && i_rsp_ready) begin
      if (exp_q.size() == 0) begin
        $display("Response arrived with no request outstanding");
        $display("** FAIL **");
        $fatal(1);
      end else begin
        compare_rsp(name_q.pop_front(), exp_q.pop_front(), o_rsp);
      end
    end
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d responses pending", cycles, exp_q.size());
      $display("** FAIL **");
      $fatal(1);
    end
  end

  initial begin
    void'($urandom(32'hd7169140));
    cycles      = 0;
    i_arst_n    = 1'b0;
    i_req_valid = 1'b0;
    i_req       = '0;
    repeat (8) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(posedge i_clk);
    test_int();
    test_mul();
    test_ctrl();
    test_csr();
    test_div();
    test_mixed();
    $display("** PASS **");
    $finish;
  end

endmodule
